// ==== filelist.f ====
source/huffman_pkg.sv
source/phase_sequencer.sv
source/symbol_histogram.sv
source/rank_sorter.sv
source/sram_writer.sv
source/huffman_top.sv
testbench/sram_model.sv
testbench/tb_huffman.sv

// ==== source/huffman_pkg.sv ====
package huffman_pkg;

	// one frame walks through these in order, then starts over
	typedef enum logic [2:0] {
		phase_read,
		phase_count_write,
		phase_sort,
		phase_rank_write,
		phase_done
	} phase_e;

	localparam int num_symbols = 6; // valid symbol values are 1 to 6

	typedef logic [2:0] sym_id_t;
	typedef logic [6:0] step_t;

	// SRAM address map
	localparam int sample_base = 1;   // first input symbol
	localparam int count_base  = 128; // one count word per symbol
	localparam int rank_base   = 134; // symbol identities, most frequent first

	localparam int sort_passes = 6; // odd-even passes needed for six lanes

endpackage

// ==== source/huffman_top.sv ====
module huffman_top #(
	parameter int data_width  = 8,
	parameter int addr_width  = 10,
	parameter int num_samples = 100
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [data_width-1:0] sram_q,
	output logic [addr_width-1:0] sram_a,
	output logic [data_width-1:0] sram_d,
	output logic                  sram_wen,
	output logic                  finish
);

	import huffman_pkg::*;

	phase_e                                   phase;
	step_t                                    step;
	logic    [num_symbols-1:0][data_width-1:0] sym_count;
	sym_id_t [num_symbols-1:0]                 rank_id;

	phase_sequencer #(
		.num_samples(num_samples)
	) sequencer_i (
		.clk  (clk),
		.reset(reset),
		.phase(phase),
		.step (step)
	);

	symbol_histogram #(
		.data_width (data_width),
		.num_samples(num_samples)
	) histogram_i (
		.clk      (clk),
		.reset    (reset),
		.phase    (phase),
		.step     (step),
		.sram_q   (sram_q),
		.sym_count(sym_count)
	);

	rank_sorter #(
		.data_width(data_width)
	) sorter_i (
		.clk      (clk),
		.reset    (reset),
		.phase    (phase),
		.step     (step),
		.sym_count(sym_count),
		.rank_id  (rank_id)
	);

	sram_writer #(
		.data_width(data_width),
		.addr_width(addr_width)
	) writer_i (
		.clk      (clk),
		.reset    (reset),
		.phase    (phase),
		.step     (step),
		.sym_count(sym_count),
		.rank_id  (rank_id),
		.sram_a   (sram_a),
		.sram_d   (sram_d),
		.sram_wen (sram_wen),
		.finish   (finish)
	);

endmodule

// ==== source/phase_sequencer.sv ====
module phase_sequencer #(
	parameter int num_samples = 100
) (
	input  logic                clk,
	input  logic                reset,
	output huffman_pkg::phase_e phase,
	output huffman_pkg::step_t  step
);

	import huffman_pkg::*;

	phase_e phase_next;
	logic   step_last;

	// index of the final step in each phase
	function automatic step_t last_step(input phase_e p);
		case (p)
			phase_read:        return step_t'(num_samples); // step 0 clears, 1..n count
			phase_count_write: return step_t'(num_symbols - 1);
			phase_sort:        return step_t'(sort_passes); // step 0 loads the lanes
			phase_rank_write:  return step_t'(num_symbols - 1);
			default:           return '0;
		endcase
	endfunction

	assign step_last = (step == last_step(phase));

	always_comb begin
		case (phase)
			phase_read:        phase_next = phase_count_write;
			phase_count_write: phase_next = phase_sort;
			phase_sort:        phase_next = phase_rank_write;
			phase_rank_write:  phase_next = phase_done;
			default:           phase_next = phase_read; // done wraps into the next frame
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= phase_read;
			step  <= '0;
		end else if (step_last) begin
			phase <= phase_next;
			step  <= '0;
		end else begin
			step <= step + 1'b1;
		end
	end

	// the other modules decode phase and step directly, so a step past the end
	// of its phase would put them all out of step with each other
	a_step_in_range: assert property (
		@(posedge clk) disable iff (reset)
		step <= last_step(phase)
	);

endmodule

// ==== source/rank_sorter.sv ====
module rank_sorter #(
	parameter int data_width = 8
) (
	input  logic                                                clk,
	input  logic                                                reset,
	input  huffman_pkg::phase_e                                 phase,
	input  huffman_pkg::step_t                                  step,
	input  logic [huffman_pkg::num_symbols-1:0][data_width-1:0] sym_count,
	output huffman_pkg::sym_id_t [huffman_pkg::num_symbols-1:0] rank_id
);

	import huffman_pkg::*;

	logic    [num_symbols-1:0][data_width-1:0] lane_count;
	logic    [num_symbols-1:0][data_width-1:0] next_count;
	sym_id_t [num_symbols-1:0]                 lane_id;
	sym_id_t [num_symbols-1:0]                 next_id;
	logic                                      load;
	logic                                      pass_en;
	logic                                      pass_offset;

	assign load    = (phase == phase_sort) && (step == '0);
	assign pass_en = (phase == phase_sort) && (step != '0) && (step <= sort_passes);

	// odd passes start at lane pair (1,2), even passes at (2,3)
	assign pass_offset = ~step[0];

	always_comb begin
		next_count = lane_count;
		next_id    = lane_id;
		if (load) begin
			for (int i = 0; i < num_symbols; i++) begin
				next_count[i] = sym_count[i];
				next_id[i]    = sym_id_t'(i + 1);
			end
		end else if (pass_en) begin
			for (int i = 0; i < num_symbols - 1; i++) begin
				// equal counts keep their order, so lower identities stay in front
				if ((i % 2) == pass_offset && lane_count[i+1] > lane_count[i]) begin
					next_count[i]   = lane_count[i+1];
					next_count[i+1] = lane_count[i];
					next_id[i]      = lane_id[i+1];
					next_id[i+1]    = lane_id[i];
				end
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			lane_count <= '0;
			lane_id    <= '0;
		end else begin
			lane_count <= next_count;
			lane_id    <= next_id;
		end
	end

	assign rank_id = lane_id;

	// six passes must leave the lanes in falling order before the ranks go out
	for (genvar g = 0; g < num_symbols - 1; g++) begin : g_order
		a_lanes_sorted: assert property (
			@(posedge clk) disable iff (reset)
			phase inside {phase_rank_write, phase_done} |->
				lane_count[g] >= lane_count[g+1]
		);
	end

endmodule

// ==== source/sram_writer.sv ====
module sram_writer #(
	parameter int data_width = 8,
	parameter int addr_width = 10
) (
	input  logic                                                clk,
	input  logic                                                reset,
	input  huffman_pkg::phase_e                                 phase,
	input  huffman_pkg::step_t                                  step,
	input  logic [huffman_pkg::num_symbols-1:0][data_width-1:0] sym_count,
	input  huffman_pkg::sym_id_t [huffman_pkg::num_symbols-1:0] rank_id,
	output logic [addr_width-1:0]                               sram_a,
	output logic [data_width-1:0]                               sram_d,
	output logic                                                sram_wen,
	output logic                                                finish
);

	import huffman_pkg::*;

	logic [addr_width-1:0] step_offset;

	assign step_offset = addr_width'(step);

	// every output is registered, so each access lands one cycle after its step
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sram_a   <= '0;
			sram_d   <= '0;
			sram_wen <= 1'b1;
			finish   <= 1'b0;
		end else begin
			sram_d   <= '0;
			sram_wen <= 1'b1;
			finish   <= 1'b0;
			case (phase)
				phase_read: begin
					// the SRAM reads asynchronously, so the symbol shows up on sram_q
					// in the following step
					sram_a <= addr_width'(sample_base) + step_offset;
				end
				phase_count_write: begin
					sram_a   <= addr_width'(count_base) + step_offset;
					sram_d   <= sym_count[step];
					sram_wen <= 1'b0;
				end
				phase_rank_write: begin
					sram_a   <= addr_width'(rank_base) + step_offset;
					sram_d   <= data_width'(rank_id[step]); // identity zero-extended
					sram_wen <= 1'b0;
				end
				phase_done: begin
					finish <= 1'b1;
				end
				default: begin
					// sort phase keeps the last address and leaves the SRAM alone
				end
			endcase
		end
	end

	// the last rank word must be written before the frame is flagged complete
	a_finish_after_writes: assert property (
		@(posedge clk) disable iff (reset)
		finish |-> sram_wen && $past(!sram_wen)
	);

endmodule

// ==== source/symbol_histogram.sv ====
module symbol_histogram #(
	parameter int data_width  = 8,
	parameter int num_samples = 100
) (
	input  logic                                                    clk,
	input  logic                                                    reset,
	input  huffman_pkg::phase_e                                     phase,
	input  huffman_pkg::step_t                                      step,
	input  logic [data_width-1:0]                                   sram_q,
	output logic [huffman_pkg::num_symbols-1:0][data_width-1:0]     sym_count
);

	import huffman_pkg::*;

	logic                  sym_valid;
	logic [2:0]            sym_sel;
	logic                  count_en;
	logic [data_width+2:0] count_sum;

	// values outside 1..6 are skipped
	assign sym_valid = (sram_q >= 1) && (sram_q <= num_symbols);
	assign sym_sel   = sram_q[2:0] - 3'd1; // symbol k lives in word k-1
	assign count_en  = (phase == phase_read) && (step != '0) && (step <= num_samples);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sym_count <= '0;
		end else if (phase == phase_read && step == '0) begin
			sym_count <= '0; // every frame starts from an empty histogram
		end else if (count_en && sym_valid) begin
			sym_count[sym_sel] <= sym_count[sym_sel] + 1'b1;
		end
	end

	always_comb begin
		count_sum = '0;
		for (int i = 0; i < num_symbols; i++) begin
			count_sum = count_sum + sym_count[i];
		end
	end

	// the counts of one frame can only add up to the samples it read
	a_sum_bounded: assert property (
		@(posedge clk) disable iff (reset)
		count_sum <= num_samples
	);

endmodule

// ==== testbench/sram_model.sv ====
module sram_model #(
	parameter int data_width = 8,
	parameter int addr_width = 10
) (
	input  logic                  clk,
	input  logic [addr_width-1:0] a,
	input  logic [data_width-1:0] d,
	input  logic                  wen,
	output logic [data_width-1:0] q
);

	logic [data_width-1:0] mem [0:(1 << addr_width)-1];

	// background pattern so that a stray read returns something recognizable
	initial begin
		for (int i = 0; i < (1 << addr_width); i++) begin
			mem[i] = data_width'(i ^ (i >> 2));
		end
	end

	assign q = mem[a]; // asynchronous read

	always @(posedge clk) begin
		if (!wen) begin
			mem[a] <= d;
		end
	end

endmodule

// ==== testbench/tb_huffman.sv ====
module tb_huffman;

	import huffman_pkg::*;

	localparam int data_width   = 8;
	localparam int addr_width   = 10;
	localparam int num_samples  = 100;
	localparam int frame_cycles = 121;
	localparam int reset_cycles = 8;
	localparam int cycle_limit  = 1000; // five frames of about 130 cycles each, resets included

	logic                  clk;
	logic                  reset;
	logic [data_width-1:0] sram_q;
	logic [addr_width-1:0] sram_a;
	logic [data_width-1:0] sram_d;
	logic                  sram_wen;
	logic                  finish;

	logic [31:0]           rng_state;
	logic [data_width-1:0] samples [1:num_samples];
	int                    ref_count [num_symbols];
	int                    ref_rank [num_symbols];
	int                    cycle_count;

	huffman_top #(
		.data_width (data_width),
		.addr_width (addr_width),
		.num_samples(num_samples)
	) dut_i (
		.clk     (clk),
		.reset   (reset),
		.sram_q  (sram_q),
		.sram_a  (sram_a),
		.sram_d  (sram_d),
		.sram_wen(sram_wen),
		.finish  (finish)
	);

	sram_model #(
		.data_width(data_width),
		.addr_width(addr_width)
	) sram_i (
		.clk(clk),
		.a  (sram_a),
		.d  (sram_d),
		.wen(sram_wen),
		.q  (sram_q)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= cycle_limit) begin
				stop_run($sformatf("timeout: the run did not complete within %0d cycles",
					cycle_limit));
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			stop_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d",
				$time, name, got, expected));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic write_sample(input int idx, input logic [data_width-1:0] value);
		samples[idx] = value;
		sram_i.mem[sample_base + idx - 1] = value;
	endtask

	// 0xff is neither a possible count nor a symbol, so stale words cannot pass
	task automatic clear_results();
		for (int k = 0; k < 2 * num_symbols; k++) begin
			sram_i.mem[count_base + k] = '1;
		end
	endtask

	// called on a falling edge, leaves reset low on a falling edge
	task automatic apply_reset();
		reset = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		check_value("sram_wen in reset", sram_wen, 1);
		check_value("finish in reset", finish, 0);
		check_value("sram_a in reset", sram_a, 0);
		check_value("sram_d in reset", sram_d, 0);
		reset = 1'b0;
	endtask

	task automatic wait_for_finish(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (finish !== 1'b1);
	endtask

	task automatic build_reference();
		bit used [num_symbols];
		int best;
		for (int s = 0; s < num_symbols; s++) begin
			ref_count[s] = 0;
			used[s]      = 1'b0;
		end
		for (int i = 1; i <= num_samples; i++) begin
			if (samples[i] >= 1 && samples[i] <= num_symbols) begin
				ref_count[samples[i] - 1]++;
			end
		end
		// pick the largest remaining count each time, the lowest symbol wins a tie
		for (int r = 0; r < num_symbols; r++) begin
			best = -1;
			for (int s = 0; s < num_symbols; s++) begin
				if (!used[s] && (best < 0 || ref_count[s] > ref_count[best])) begin
					best = s;
				end
			end
			used[best]  = 1'b1;
			ref_rank[r] = best + 1;
		end
	endtask

	task automatic compare_results();
		int valid;
		int sum;
		valid = 0;
		sum   = 0;
		for (int i = 1; i <= num_samples; i++) begin
			if (samples[i] >= 1 && samples[i] <= num_symbols) begin
				valid++;
			end
		end
		for (int k = 0; k < num_symbols; k++) begin
			sum += sram_i.mem[count_base + k];
		end
		check_value("sum of counts", sum, valid);
		for (int k = 0; k < num_symbols; k++) begin
			check_value($sformatf("mem[%0d] count of symbol %0d", count_base + k, k + 1),
				sram_i.mem[count_base + k], ref_count[k]);
		end
		for (int k = 0; k < num_symbols; k++) begin
			check_value($sformatf("mem[%0d] rank %0d", rank_base + k, k + 1),
				sram_i.mem[rank_base + k], ref_rank[k]);
		end
	endtask

	task automatic random_symbols_frame();
		int cycles;
		@(negedge clk);
		for (int i = 1; i <= num_samples; i++) begin
			rng_state = xorshift32(rng_state);
			write_sample(i, data_width'(rng_state % num_symbols + 1));
		end
		clear_results();
		apply_reset();
		// the whole read phase passes without a write or a finish
		for (int c = 1; c <= num_samples + 1; c++) begin
			@(negedge clk);
			check_value("sram_wen during read", sram_wen, 1);
			check_value("finish during read", finish, 0);
		end
		@(negedge clk);
		check_value("sram_wen at first count write", sram_wen, 0);
		check_value("sram_a at first count write", sram_a, count_base);
		wait_for_finish(cycles);
		check_value("cycles from reset to finish", cycles + num_samples + 2, frame_cycles);
		build_reference();
		compare_results();
	endtask

	task automatic invalid_symbols_frame();
		int cycles;
		int pick;
		@(negedge clk);
		for (int i = 1; i <= num_samples; i++) begin
			rng_state = xorshift32(rng_state);
			pick      = rng_state % 9;
			case (pick)
				6:       write_sample(i, 0);
				7:       write_sample(i, 7);
				8:       write_sample(i, 255);
				default: write_sample(i, data_width'(pick + 1));
			endcase
		end
		clear_results();
		apply_reset();
		wait_for_finish(cycles);
		build_reference();
		compare_results();
	endtask

	task automatic reversed_order_frame();
		int per_symbol [num_symbols];
		int cycles;
		int idx;
		per_symbol = '{2, 8, 14, 20, 20, 36}; // symbols 4 and 5 tie
		idx        = 1;
		@(negedge clk);
		for (int s = num_symbols; s >= 1; s--) begin
			repeat (per_symbol[s - 1]) begin
				write_sample(idx, data_width'(s));
				idx++;
			end
		end
		clear_results();
		apply_reset();
		wait_for_finish(cycles);
		check_value("most frequent symbol", sram_i.mem[rank_base], 6);
		build_reference();
		compare_results();
	endtask

	task automatic back_to_back_frames();
		int cycles;
		@(negedge clk);
		for (int i = 1; i <= num_samples; i++) begin
			rng_state = xorshift32(rng_state);
			write_sample(i, data_width'(rng_state % num_symbols + 1));
		end
		clear_results();
		apply_reset();
		wait_for_finish(cycles);
		build_reference();
		compare_results();
		@(negedge clk);
		check_value("finish one cycle after the pulse", finish, 0);
		clear_results(); // the second frame has to write everything again
		wait_for_finish(cycles);
		check_value("cycles between finish pulses", cycles + 1, frame_cycles);
		compare_results(); // same data, so a histogram that was not cleared shows up here
	endtask

	initial begin
		reset     = 1'b1;
		rng_state = 32'h8b01_7c72;
		random_symbols_frame();
		invalid_symbols_frame();
		reversed_order_frame();
		back_to_back_frames();
		$display("=== PASS ===");
		$finish;
	end

endmodule
